/* ex_alu.sv */
// Combinational ALU and branch comparator of the execute stage, instantiated by ex_stage
`timescale 1ns/1ns
`include "rv32_ex_defs.svh"

module ex_alu
  import rv32_ex_pkg::*;
(
  input  logic [`XLEN-1:0] i_a,
  input  logic [`XLEN-1:0] i_b,
  input  func_op_u         i_func_op,
  output logic [`XLEN-1:0] o_alu_out,
  output logic             o_br_en
);

  logic [4:0] shamt;

  // Only the low five bits of b count for shifts
  assign shamt = i_b[4:0];

  always_comb begin
    case (i_func_op.alu)
      ADD:     o_alu_out = i_a + i_b;
      SUB:     o_alu_out = i_a - i_b;
      SLL:     o_alu_out = i_a << shamt;
      SLT:     o_alu_out = {{(`XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      SLTU:    o_alu_out = {{(`XLEN-1){1'b0}}, i_a < i_b};
      XOR:     o_alu_out = i_a ^ i_b;
      SRL:     o_alu_out = i_a >> shamt;
      SRA:     o_alu_out = $signed(i_a) >>> shamt;
      OR:      o_alu_out = i_a | i_b;
      AND:     o_alu_out = i_a & i_b;
      PASS_B:  o_alu_out = i_b;
      default: o_alu_out = i_a + i_b;
    endcase
  end

  // Same word seen as a branch funct3
  always_comb begin
    case (i_func_op.cmp.op)
      BEQ:     o_br_en = (i_a == i_b);
      BNE:     o_br_en = (i_a != i_b);
      BLT:     o_br_en = ($signed(i_a) < $signed(i_b));
      BGE:     o_br_en = ($signed(i_a) >= $signed(i_b));
      BLTU:    o_br_en = (i_a < i_b);
      BGEU:    o_br_en = (i_a >= i_b);
      default: o_br_en = 1'b0;
    endcase
  end

endmodule

/* ex_control.sv */
// Execute-stage control: start pulses, stalls, result select, branch target, EX/MEM register
`timescale 1ns/1ns
`include "rv32_ex_defs.svh"

module ex_control
  import rv32_ex_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_ex_stall,
  input  logic                   i_dmem_stall,
  input  logic                   i_wb_forward,
  input  func_sel_e              i_func_sel,
  input  logic                   i_branch,
  input  logic                   i_target_rs1,
  input  logic [`XLEN-1:0]       i_pc,
  input  logic [`XLEN-1:0]       i_imm,
  input  logic [`XLEN-1:0]       i_rs1_fwd,
  input  logic [`XLEN-1:0]       i_rs2_fwd,
  input  logic [`REG_ADDR_W-1:0] i_rd_addr,
  input  logic                   i_regf_we,
  input  logic [`XLEN-1:0]       i_alu_out,
  input  logic                   i_br_en,
  input  logic                   i_mul_busy,
  input  logic [`XLEN-1:0]       i_mul_result,
  input  logic                   i_div_busy,
  input  logic [`XLEN-1:0]       i_div_result,
  output logic                   o_mul_start,
  output logic                   o_div_start,
  output logic                   o_func_stall,
  output logic                   o_branch_taken,
  output logic [`XLEN-1:0]       o_pc_offset,
  output logic [`XLEN-1:0]       o_func_out,
  output logic [`XLEN-1:0]       o_rs2_data,
  output logic [`REG_ADDR_W-1:0] o_rd_addr,
  output logic                   o_regf_we
);

  logic             is_mul;
  logic             is_div;
  logic             mem_wait;
  logic             mul_latch;
  logic             div_latch;
  logic             advance;
  logic [`XLEN-1:0] func_next;
  logic [`XLEN-1:0] target;

  assign is_mul = (i_func_sel == SEL_MUL);
  assign is_div = (i_func_sel == SEL_DIV);

  // Load result feeding an operand has not arrived yet
  assign mem_wait = i_wb_forward && i_dmem_stall;

  // One pulse per instruction, the latch blocks a restart under back-pressure
  assign o_mul_start = is_mul && !mem_wait && !mul_latch;
  assign o_div_start = is_div && !mem_wait && !div_latch;

  assign o_func_stall = o_mul_start || i_mul_busy || o_div_start || i_div_busy ||
                        ((is_mul || is_div) && mem_wait);
  assign advance = !i_ex_stall && !o_func_stall;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mul_latch <= 1'b0;
      div_latch <= 1'b0;
    end else if (advance) begin
      mul_latch <= 1'b0;
      div_latch <= 1'b0;
    end else begin
      if (o_mul_start) mul_latch <= 1'b1;
      if (o_div_start) div_latch <= 1'b1;
    end
  end

  always_comb begin
    case (i_func_sel)
      SEL_CMP:  func_next = {{(`XLEN-1){1'b0}}, i_br_en};
      SEL_LINK: func_next = i_pc + `XLEN'(`PC_STEP);
      SEL_MUL:  func_next = i_mul_result;
      SEL_DIV:  func_next = i_div_result;
      default:  func_next = i_alu_out;
    endcase
  end

  // JALR clears bit 0 of the target
  assign target         = (i_target_rs1 ? i_rs1_fwd : i_pc) + i_imm;
  assign o_pc_offset    = i_target_rs1 ? {target[`XLEN-1:1], 1'b0} : target;
  assign o_branch_taken = i_branch && i_br_en;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_func_out <= '0;
      o_rs2_data <= '0;
      o_rd_addr  <= '0;
      o_regf_we  <= 1'b0;
    end else if (advance) begin
      o_func_out <= func_next;
      o_rs2_data <= i_rs2_fwd;
      o_rd_addr  <= i_rd_addr;
      o_regf_we  <= i_regf_we;
    end
  end

  // Each start pulse must be answered by busy in the following cycle
  mul_start_ack: assert property (@(posedge clk) disable iff (rst) o_mul_start |=> i_mul_busy);
  div_start_ack: assert property (@(posedge clk) disable iff (rst) o_div_start |=> i_div_busy);

endmodule

/* ex_divider.sv */
// Iterative restoring divider for the M extension, started by ex_control
`timescale 1ns/1ns
`include "rv32_ex_defs.svh"

module ex_divider
  import rv32_ex_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             i_start,
  input  logic [`XLEN-1:0] i_a,
  input  logic [`XLEN-1:0] i_b,
  input  md_op_e           i_md_op,
  output logic             o_busy,
  output logic [`XLEN-1:0] o_result,
  output logic             o_div_by_zero
);

  logic [`XLEN-1:0] quo;
  logic [`XLEN-1:0] rem_r;
  logic [`XLEN-1:0] dvsr;
  logic [`XLEN-1:0] dividend;
  logic [`XLEN-1:0] q_out;
  logic [`XLEN-1:0] r_out;
  logic [`XLEN:0]   shifted;
  logic [`XLEN:0]   diff;
  logic             ge;
  logic             is_signed;
  logic             q_neg;
  logic             r_neg;
  logic             ovf;
  md_op_e           op;
  logic [4:0]       step;

  assign is_signed = (i_md_op == DIV) || (i_md_op == REM);

  // One restoring step: shift in the next dividend bit, subtract if it fits
  assign shifted = {rem_r, quo[`XLEN-1]};
  assign diff    = shifted - {1'b0, dvsr};
  assign ge      = (shifted >= {1'b0, dvsr});

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_busy <= 1'b0;
      step   <= '0;
    end else if (i_start) begin
      o_busy <= 1'b1;
      step   <= '0;
    end else if (o_busy) begin
      step <= step + 5'd1;
      if (step == 5'd31) o_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      quo           <= (is_signed && i_a[`XLEN-1]) ? -i_a : i_a;
      dvsr          <= (is_signed && i_b[`XLEN-1]) ? -i_b : i_b;
      rem_r         <= '0;
      dividend      <= i_a;
      op            <= i_md_op;
      q_neg         <= is_signed && (i_a[`XLEN-1] ^ i_b[`XLEN-1]);
      r_neg         <= is_signed && i_a[`XLEN-1];
      o_div_by_zero <= (i_b == '0);
      ovf           <= is_signed && (i_a == {1'b1, {(`XLEN-1){1'b0}}}) && (i_b == '1);
    end else if (o_busy) begin
      quo   <= {quo[`XLEN-2:0], ge};
      rem_r <= ge ? diff[`XLEN-1:0] : shifted[`XLEN-1:0];
    end
  end

  always_comb begin
    q_out = q_neg ? -quo : quo;
    r_out = r_neg ? -rem_r : rem_r;
    // RISC-V defined results, no trap
    if (o_div_by_zero) begin
      q_out = '1;
      r_out = dividend;
    end else if (ovf) begin
      q_out = dividend;
      r_out = '0;
    end
    o_result = ((op == REM) || (op == REMU)) ? r_out : q_out;
  end

  start_while_busy: assert property (@(posedge clk) disable iff (rst) i_start |-> !o_busy);

endmodule

/* ex_multiplier.sv */
// Iterative shift-add multiplier for the M extension, started by ex_control
`timescale 1ns/1ns
`include "rv32_ex_defs.svh"

module ex_multiplier
  import rv32_ex_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             i_start,
  input  logic [`XLEN-1:0] i_a,
  input  logic [`XLEN-1:0] i_b,
  input  md_op_e           i_md_op,
  output logic             o_busy,
  output logic [`XLEN-1:0] o_result
);

  logic [`XLEN-1:0]   mcand;
  logic [2*`XLEN-1:0] prod;
  logic [2*`XLEN-1:0] full;
  logic [`XLEN:0]     sum;
  logic               a_neg;
  logic               b_neg;
  logic               neg;
  md_op_e             op;
  logic [4:0]         step;

  // MULHU treats both operands as unsigned, MULHSU only b
  assign a_neg = (i_md_op != MULHU) && i_a[`XLEN-1];
  assign b_neg = ((i_md_op == MUL) || (i_md_op == MULH)) && i_b[`XLEN-1];

  // Add the multiplicand into the upper half when the multiplier LSB is set
  assign sum = {1'b0, prod[2*`XLEN-1:`XLEN]} + (prod[0] ? {1'b0, mcand} : '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_busy <= 1'b0;
      step   <= '0;
    end else if (i_start) begin
      o_busy <= 1'b1;
      step   <= '0;
    end else if (o_busy) begin
      step <= step + 5'd1;
      if (step == 5'd31) o_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      mcand <= a_neg ? -i_a : i_a;
      prod  <= {{`XLEN{1'b0}}, (b_neg ? -i_b : i_b)};
      neg   <= a_neg ^ b_neg;
      op    <= i_md_op;
    end else if (o_busy) begin
      prod <= {sum, prod[`XLEN-1:1]};
    end
  end

  assign full     = neg ? -prod : prod;
  assign o_result = (op == MUL) ? full[`XLEN-1:0] : full[2*`XLEN-1:`XLEN];

  // ex_control must wait for the previous operation to finish
  start_while_busy: assert property (@(posedge clk) disable iff (rst) i_start |-> !o_busy);

endmodule

/* ex_operand_unit.sv */
// Forwarding decision and operand muxes for the execute stage, instantiated by ex_stage
`timescale 1ns/1ns
`include "rv32_ex_defs.svh"

module ex_operand_unit
  import rv32_ex_pkg::*;
(
  input  logic [`REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [`REG_ADDR_W-1:0] i_rs2_addr,
  input  logic [`XLEN-1:0]       i_rs1_rdata,
  input  logic [`XLEN-1:0]       i_rs2_rdata,
  input  logic [`XLEN-1:0]       i_pc,
  input  logic [`XLEN-1:0]       i_imm,
  input  logic                   i_alu1_pc,
  input  logic                   i_alu2_imm,
  input  logic [`REG_ADDR_W-1:0] i_ex_rd_addr,
  input  logic                   i_ex_regf_we,
  input  logic [`XLEN-1:0]       i_ex_func_out,
  input  logic [`REG_ADDR_W-1:0] i_mem_rd_addr,
  input  logic                   i_mem_regf_we,
  input  logic [`XLEN-1:0]       i_wb_data,
  output logic [`XLEN-1:0]       o_a,
  output logic [`XLEN-1:0]       o_b,
  output logic [`XLEN-1:0]       o_rs1_fwd,
  output logic [`XLEN-1:0]       o_rs2_fwd,
  output logic                   o_wb_forward
);

  fwd_src_e src1;
  fwd_src_e src2;

  // Execute register wins over writeback, x0 never forwards
  function automatic fwd_src_e pick_src(input logic [`REG_ADDR_W-1:0] rs);
    if (rs == '0) return FWD_REGF;
    if (i_ex_regf_we && (i_ex_rd_addr == rs)) return FWD_EX;
    if (i_mem_regf_we && (i_mem_rd_addr == rs)) return FWD_WB;
    return FWD_REGF;
  endfunction

  assign src1 = pick_src(i_rs1_addr);
  assign src2 = pick_src(i_rs2_addr);

  assign o_rs1_fwd = (src1 == FWD_EX) ? i_ex_func_out :
                     (src1 == FWD_WB) ? i_wb_data : i_rs1_rdata;
  assign o_rs2_fwd = (src2 == FWD_EX) ? i_ex_func_out :
                     (src2 == FWD_WB) ? i_wb_data : i_rs2_rdata;

  assign o_a = i_alu1_pc  ? i_pc  : o_rs1_fwd;
  assign o_b = i_alu2_imm ? i_imm : o_rs2_fwd;

  // Controller holds off iterative ops until the load data is there
  assign o_wb_forward = (src1 == FWD_WB) || (src2 == FWD_WB);

endmodule

/* ex_stage.sv */
// Top level of the RV32IM execute stage, between the decode and memory stages
`timescale 1ns/1ns
`include "rv32_ex_defs.svh"

module ex_stage
  import rv32_ex_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  // From decode
  input  logic [`XLEN-1:0]       i_pc,
  input  logic [`XLEN-1:0]       i_imm,
  input  logic [`REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [`REG_ADDR_W-1:0] i_rs2_addr,
  input  logic [`XLEN-1:0]       i_rs1_rdata,
  input  logic [`XLEN-1:0]       i_rs2_rdata,
  input  logic [`REG_ADDR_W-1:0] i_rd_addr,
  input  logic                   i_regf_we,
  input  logic                   i_alu1_pc,
  input  logic                   i_alu2_imm,
  input  func_sel_e              i_func_sel,
  input  func_op_u               i_func_op,
  input  logic                   i_branch,
  input  logic                   i_target_rs1,
  // From memory and writeback
  input  logic [`REG_ADDR_W-1:0] i_mem_rd_addr,
  input  logic                   i_mem_regf_we,
  input  logic [`XLEN-1:0]       i_wb_data,
  input  logic                   i_ex_stall,
  input  logic                   i_dmem_stall,
  output logic [`XLEN-1:0]       o_func_out,
  output logic [`XLEN-1:0]       o_rs2_data,
  output logic [`REG_ADDR_W-1:0] o_rd_addr,
  output logic                   o_regf_we,
  output logic                   o_branch_taken,
  output logic [`XLEN-1:0]       o_pc_offset,
  output logic                   o_func_stall
);

  logic [`XLEN-1:0] a, b, rs1_fwd, rs2_fwd, alu_out, mul_result, div_result;
  logic             wb_forward, br_en, mul_start, mul_busy, div_start, div_busy;

  ex_operand_unit operand_i (
    .i_rs1_addr(i_rs1_addr), .i_rs2_addr(i_rs2_addr), .i_rs1_rdata(i_rs1_rdata),
    .i_rs2_rdata(i_rs2_rdata), .i_pc(i_pc), .i_imm(i_imm), .i_alu1_pc(i_alu1_pc),
    .i_alu2_imm(i_alu2_imm), .i_ex_rd_addr(o_rd_addr), .i_ex_regf_we(o_regf_we),
    .i_ex_func_out(o_func_out), .i_mem_rd_addr(i_mem_rd_addr),
    .i_mem_regf_we(i_mem_regf_we), .i_wb_data(i_wb_data), .o_a(a), .o_b(b),
    .o_rs1_fwd(rs1_fwd), .o_rs2_fwd(rs2_fwd), .o_wb_forward(wb_forward)
  );

  ex_alu alu_i (.i_a(a), .i_b(b), .i_func_op(i_func_op), .o_alu_out(alu_out), .o_br_en(br_en));

  ex_multiplier mul_i (
    .clk(clk), .rst(rst), .i_start(mul_start), .i_a(a), .i_b(b),
    .i_md_op(i_func_op.md.op), .o_busy(mul_busy), .o_result(mul_result)
  );

  // Divide-by-zero flag is reserved for a future trap unit
  ex_divider div_i (
    .clk(clk), .rst(rst), .i_start(div_start), .i_a(a), .i_b(b),
    .i_md_op(i_func_op.md.op), .o_busy(div_busy), .o_result(div_result), .o_div_by_zero()
  );

  ex_control ctrl_i (
    .clk(clk), .rst(rst), .i_ex_stall(i_ex_stall), .i_dmem_stall(i_dmem_stall),
    .i_wb_forward(wb_forward), .i_func_sel(i_func_sel), .i_branch(i_branch),
    .i_target_rs1(i_target_rs1), .i_pc(i_pc), .i_imm(i_imm), .i_rs1_fwd(rs1_fwd),
    .i_rs2_fwd(rs2_fwd), .i_rd_addr(i_rd_addr), .i_regf_we(i_regf_we),
    .i_alu_out(alu_out), .i_br_en(br_en), .i_mul_busy(mul_busy),
    .i_mul_result(mul_result), .i_div_busy(div_busy), .i_div_result(div_result),
    .o_mul_start(mul_start), .o_div_start(div_start), .o_func_stall(o_func_stall),
    .o_branch_taken(o_branch_taken), .o_pc_offset(o_pc_offset), .o_func_out(o_func_out),
    .o_rs2_data(o_rs2_data), .o_rd_addr(o_rd_addr), .o_regf_we(o_regf_we)
  );

endmodule

/* ex_stage_input.txt */
# name pc imm rs1 rs2 rs1_data rs2_data rd we alu1_pc alu2_imm sel op br tgt_rs1 mem_rd mem_we
#   wb_data ex_stall_cyc dmem_stall_cyc | exp_func_out exp_rd exp_we exp_br_taken exp_pc_offset
add 100 0 1 2 5 7 3 1 0 0 0 0 0 0 0 0 0 0 0 c 3 1 0 100
addi 100 20 4 0 10 0 5 1 0 1 0 0 0 0 0 0 0 0 0 30 5 1 0 120
sub 100 0 6 7 10 13 8 1 0 0 0 1 0 0 0 0 0 0 0 fffffffd 8 1 0 100
sra 100 0 9 a 80000000 4 b 1 0 0 0 7 0 0 0 0 0 0 0 f8000000 b 1 0 100
sltu 100 0 c d 1 ffffffff e 1 0 0 0 4 0 0 0 0 0 0 0 1 e 1 0 100
slt 100 0 c d 1 ffffffff f 1 0 0 0 3 0 0 0 0 0 0 0 0 f 1 0 100
auipc 200 1000 0 0 0 0 10 1 1 1 0 0 0 0 0 0 0 0 0 1200 10 1 0 1200
fwd_ex 100 1 10 0 dead 0 11 1 0 1 0 0 0 0 0 0 0 0 0 1201 11 1 0 101
fwd_wb 100 0 12 13 0 2 14 1 0 0 0 0 0 0 12 1 40 0 0 42 14 1 0 100
fwd_x0 100 3 0 0 7 0 15 1 0 1 0 0 0 0 0 1 99 0 0 a 15 1 0 103
beq 300 40 1 2 5 5 0 0 0 0 1 0 1 0 0 0 0 0 0 1 0 0 1 340
bne 300 40 1 2 5 5 0 0 0 0 1 1 1 0 0 0 0 0 0 0 0 0 0 340
blt 300 40 1 2 ffffffff 1 0 0 0 0 1 4 1 0 0 0 0 0 0 1 0 0 1 340
bge 300 40 1 2 ffffffff 1 0 0 0 0 1 5 1 0 0 0 0 0 0 0 0 0 0 340
bltu 300 40 1 2 ffffffff 1 0 0 0 0 1 6 1 0 0 0 0 0 0 0 0 0 0 340
bgeu 300 40 1 2 ffffffff 1 0 0 0 0 1 7 1 0 0 0 0 0 0 1 0 0 1 340
jal 400 80 0 0 0 0 1 1 0 0 2 0 1 0 0 0 0 0 0 404 1 1 1 480
jalr 500 10 5 0 1001 0 2 1 0 0 2 7 1 1 0 0 0 0 0 504 2 1 1 1010
mul 100 0 7 8 fffffffd 7 9 1 0 0 3 0 0 0 0 0 0 0 0 ffffffeb 9 1 0 100
mulh 100 0 7 8 80000000 80000000 9 1 0 0 3 1 0 0 0 0 0 0 0 40000000 9 1 0 100
mulhsu 100 0 7 8 ffffffff ffffffff 9 1 0 0 3 2 0 0 0 0 0 0 0 ffffffff 9 1 0 100
mulhu 100 0 7 8 ffffffff ffffffff 9 1 0 0 3 3 0 0 0 0 0 0 0 fffffffe 9 1 0 100
div 100 0 7 8 fffffff9 2 9 1 0 0 4 4 0 0 0 0 0 0 0 fffffffd 9 1 0 100
divu_zero 100 0 7 8 1234 0 9 1 0 0 4 5 0 0 0 0 0 0 0 ffffffff 9 1 0 100
rem 100 0 7 8 fffffff9 2 9 1 0 0 4 6 0 0 0 0 0 0 0 ffffffff 9 1 0 100
remu 100 0 7 8 13 5 9 1 0 0 4 7 0 0 0 0 0 0 0 4 9 1 0 100
div_ovf 100 0 7 8 80000000 ffffffff 9 1 0 0 4 4 0 0 0 0 0 0 0 80000000 9 1 0 100
rem_ovf 100 0 7 8 80000000 ffffffff 9 1 0 0 4 6 0 0 0 0 0 0 0 0 9 1 0 100
rem_zero 100 0 7 8 1234 0 9 1 0 0 4 6 0 0 0 0 0 0 0 1234 9 1 0 100
stall_alu 100 0 7 8 1 1 9 1 0 0 0 0 0 0 0 0 0 3 0 2 9 1 0 100
stall_mul 100 0 7 8 6 7 9 1 0 0 3 0 0 0 0 0 0 5 0 2a 9 1 0 100
dmem_mul 100 0 12 8 0 3 a 1 0 0 3 0 0 0 12 1 9 0 4 1b a 1 0 100

/* run_sim.sh */
#!/bin/bash
# Build with Verilator and run, pass or fail is read from sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_ex_stage \
  -o sim_tb_ex_stage > build.log 2>&1 || { echo "Build error, see build.log"; exit 1; }
./obj_dir/sim_tb_ex_stage > sim.log 2>&1 || true
grep -q "Simulation FAILED" sim.log && { cat sim.log; exit 1; } || true
grep -q "Simulation PASSED" sim.log && { cat sim.log; exit 0; } || { cat sim.log; exit 1; }

/* rv32_ex_defs.svh */
// Width macros for the RV32 execute stage, included by the package and every RTL file
`ifndef RV32_EX_DEFS_SVH
`define RV32_EX_DEFS_SVH

// Data path width
`define XLEN 32

// Register file address width
`define REG_ADDR_W 5

// Function-operation word width, shared by the ALU, compare and M-extension views
`define FUNC_OP_W 4

// Byte offset to the next sequential instruction
`define PC_STEP 4

`endif

/* rv32_ex_pkg.sv */
// Shared types of the execute stage; modules import it with a wildcard in their header
`include "rv32_ex_defs.svh"

package rv32_ex_pkg;

  // Result source for the execute/memory register
  typedef enum logic [2:0] {SEL_ALU, SEL_CMP, SEL_LINK, SEL_MUL, SEL_DIV} func_sel_e;

  // Where a source register value comes from
  typedef enum logic [1:0] {FWD_REGF, FWD_EX, FWD_WB} fwd_src_e;

  typedef enum logic [`FUNC_OP_W-1:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
  } alu_op_e;

  // Branch funct3 encodings
  typedef enum logic [2:0] {
    BEQ = 3'b000, BNE = 3'b001, BLT = 3'b100, BGE = 3'b101, BLTU = 3'b110, BGEU = 3'b111
  } cmp_op_e;

  // M-extension funct3 encodings
  typedef enum logic [2:0] {
    MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
  } md_op_e;

  typedef struct packed {
    logic    pad;
    cmp_op_e op;
  } cmp_view_t;

  typedef struct packed {
    logic   pad;
    md_op_e op;
  } md_view_t;

  // One decode word, read differently by each functional unit
  typedef union packed {
    alu_op_e   alu;
    cmp_view_t cmp;
    md_view_t  md;
  } func_op_u;

endpackage

/* src.f */
+incdir+.
rv32_ex_pkg.sv
ex_operand_unit.sv
ex_alu.sv
ex_multiplier.sv
ex_divider.sv
ex_control.sv
ex_stage.sv
tb_ex_stage.sv

/* tb_ex_stage.sv */
// Self-checking testbench for ex_stage, driven by the vectors in ex_stage_input.txt
`timescale 1ns/1ns
`include "rv32_ex_defs.svh"

module tb_ex_stage
  import rv32_ex_pkg::*;
();

  logic clk = 1'b0;
  logic rst;
  logic [`XLEN-1:0] i_pc, i_imm, i_rs1_rdata, i_rs2_rdata, i_wb_data;
  logic [`REG_ADDR_W-1:0] i_rs1_addr, i_rs2_addr, i_rd_addr, i_mem_rd_addr;
  logic i_regf_we, i_alu1_pc, i_alu2_imm, i_branch, i_target_rs1;
  logic i_mem_regf_we, i_ex_stall, i_dmem_stall;
  func_sel_e i_func_sel;
  func_op_u i_func_op;
  logic [`XLEN-1:0] o_func_out, o_rs2_data, o_pc_offset;
  logic [`REG_ADDR_W-1:0] o_rd_addr;
  logic o_regf_we, o_branch_taken, o_func_stall;

  string lines[$];
  reg [8*24-1:0] tname;
  logic [`XLEN-1:0] prev_out;
  logic [`REG_ADDR_W-1:0] prev_rd;
  logic prev_we;
  int n_vec;
  bit loaded;

  ex_stage dut_i (.*);

  always #2 clk = ~clk;

  task automatic check_word(input string what, input logic [`XLEN-1:0] exp,
                            input logic [`XLEN-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0s %0s: expected %h, actual %h", tname, what, exp, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_addr(input string what, input logic [`REG_ADDR_W-1:0] exp,
                            input logic [`REG_ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0s %0s: expected %h, actual %h", tname, what, exp, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0s %0s: expected %b, actual %b", tname, what, exp, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // Forwarding rule applied to the EX register left by the previous vector
  function automatic logic [`XLEN-1:0] forwarded_value(input logic [`REG_ADDR_W-1:0] rs,
                                                      input logic [`XLEN-1:0] rdata);
    if (rs == '0) return rdata;
    if (prev_we && (prev_rd == rs)) return prev_out;
    if (i_mem_regf_we && (i_mem_rd_addr == rs)) return i_wb_data;
    return rdata;
  endfunction

  // Called just after a rising edge plus the drive delay
  task automatic run_vector(input string line);
    logic [31:0] f [24];
    int ex_cnt;
    int dm_cnt;
    logic [`XLEN-1:0] exp_rs2;
    void'($sscanf(line,
      "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
      tname, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
      f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23]));
    i_pc          = f[0];
    i_imm         = f[1];
    i_rs1_addr    = f[2][`REG_ADDR_W-1:0];
    i_rs2_addr    = f[3][`REG_ADDR_W-1:0];
    i_rs1_rdata   = f[4];
    i_rs2_rdata   = f[5];
    i_rd_addr     = f[6][`REG_ADDR_W-1:0];
    i_regf_we     = f[7][0];
    i_alu1_pc     = f[8][0];
    i_alu2_imm    = f[9][0];
    i_func_sel    = func_sel_e'(f[10][2:0]);
    i_func_op     = func_op_u'(f[11][`FUNC_OP_W-1:0]);
    i_branch      = f[12][0];
    i_target_rs1  = f[13][0];
    i_mem_rd_addr = f[14][`REG_ADDR_W-1:0];
    i_mem_regf_we = f[15][0];
    i_wb_data     = f[16];
    ex_cnt        = f[17];
    dm_cnt        = f[18];
    i_ex_stall    = (ex_cnt > 0);
    i_dmem_stall  = (dm_cnt > 0);
    // Store data is the forwarded rs2
    exp_rs2       = forwarded_value(i_rs2_addr, i_rs2_rdata);
    #1;
    check_bit("branch_taken", f[22][0], o_branch_taken);
    check_word("pc_offset", f[23], o_pc_offset);
    // Register must hold the last result while stalled
    while (ex_cnt > 0 || dm_cnt > 0) begin
      @(posedge clk);
      #1;
      check_word("held func_out", prev_out, o_func_out);
      if (dm_cnt > 0) check_bit("func_stall on dmem wait", 1'b1, o_func_stall);
      if (ex_cnt > 0) ex_cnt--;
      if (dm_cnt > 0) dm_cnt--;
      i_ex_stall   = (ex_cnt > 0);
      i_dmem_stall = (dm_cnt > 0);
    end
    while (o_func_stall) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    check_word("func_out", f[19], o_func_out);
    check_word("rs2_data", exp_rs2, o_rs2_data);
    check_addr("rd_addr", f[20][`REG_ADDR_W-1:0], o_rd_addr);
    check_bit("regf_we", f[21][0], o_regf_we);
    prev_out = f[19];
    prev_rd  = f[20][`REG_ADDR_W-1:0];
    prev_we  = f[21][0];
  endtask

  initial begin
    int fd;
    string line;
    {i_pc, i_imm, i_rs1_rdata, i_rs2_rdata, i_wb_data} = '0;
    {i_rs1_addr, i_rs2_addr, i_rd_addr, i_mem_rd_addr} = '0;
    {i_regf_we, i_alu1_pc, i_alu2_imm, i_branch, i_target_rs1} = '0;
    {i_mem_regf_we, i_ex_stall, i_dmem_stall} = '0;
    i_func_sel = SEL_ALU;
    i_func_op  = func_op_u'('0);
    prev_out   = '0;
    prev_rd    = '0;
    prev_we    = 1'b0;
    rst        = 1'b1;
    fd = $fopen("ex_stage_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file ex_stage_input.txt");
      $display("Simulation FAILED");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 2 && line[0] != "#") lines.push_back(line);
    end
    $fclose(fd);
    n_vec  = lines.size();
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (lines[k]) run_vector(lines[k]);
    $display("Simulation PASSED");
    $finish;
  end

  // Forty cycles per vector covers 33 iterative cycles plus stalls
  initial begin
    wait (loaded);
    #((n_vec * 40 + 10) * 4);
    $display("Timeout: the testbench hung waiting for the DUT");
    $display("Simulation FAILED");
    $fatal(1);
  end

endmodule
